// ==== tb.f ====
+incdir+hw
+incdir+verif
hw/fpu_pkg.sv
hw/adder.sv
hw/priority_encoder.sv
hw/fpu_align.sv
hw/fpu_normalize.sv
hw/fpu.sv
hw/fpu_top.sv
verif/fpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := fpu_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/fpu_ref_model.svh ====
`ifndef FPU_REF_MODEL_SVH
`define FPU_REF_MODEL_SVH

// zero and subnormal words read as zero of the same sign.
function automatic logic [31:0] flush_subnormal(input logic [31:0] w);
    return (w[30:23] == 8'd0) ? {w[31], 31'd0} : w;
endfunction

// exact sum of two words, truncated toward zero.
// y arrives already negated for subtract.
function automatic logic [31:0] truncated_sum(input logic [31:0] x, input logic [31:0] y);
    logic [31:0] hi;
    logic [31:0] lo;
    logic [79:0] m_hi;
    logic [79:0] m_lo;
    logic [79:0] mag;
    logic        sign;
    int          d;
    int          p;
    int          e;
    hi = (y[30:23] > x[30:23]) ? y : x;
    lo = (y[30:23] > x[30:23]) ? x : y;
    // integer significands, hidden one at bit 23.
    m_hi = (hi[30:23] == 8'd0) ? 80'd0 : {56'd0, 1'b1, hi[22:0]};
    m_lo = (lo[30:23] == 8'd0) ? 80'd0 : {56'd0, 1'b1, lo[22:0]};
    // past 40 bits the small term only sets the direction of the cut.
    d    = int'(hi[30:23]) - int'(lo[30:23]);
    d    = (d > 40) ? 40 : d;
    m_hi = m_hi << d;
    sign = (m_hi >= m_lo) ? hi[31] : lo[31];
    if (hi[31] == lo[31]) begin
        mag = m_hi + m_lo;
    end else begin
        mag = (m_hi >= m_lo) ? (m_hi - m_lo) : (m_lo - m_hi);
    end
    // exact cancellation.
    if (mag == 80'd0) begin
        return 32'd0;
    end
    p = 0;
    for (int i = 0; i < 80; i++) begin
        if (mag[i]) begin
            p = i;
        end
    end
    // biased exponent of the leading one.
    e = int'(hi[30:23]) - d + p - 23;
    if (e <= 0) begin
        return {sign, 31'd0};
    end
    if (e >= 255) begin
        return {sign, 8'hff, 23'd0};
    end
    // 23 bits under the leading one survive.
    mag = (p >= 23) ? (mag >> (p - 23)) : (mag << (23 - p));
    return {sign, e[7:0], mag[22:0]};
endfunction

// signed order of two flushed words, minus zero below plus zero.
function automatic logic signed_less(input logic [31:0] x, input logic [31:0] y);
    if (x[31] != y[31]) begin
        return x[31];
    end
    return x[31] ? (x[30:0] > y[30:0]) : (x[30:0] < y[30:0]);
endfunction

function automatic logic [31:0] expected_result(
    input fpu_pkg::fpu_op_e op,
    input logic [31:0]      a,
    input logic [31:0]      b
);
    logic [31:0] x;
    logic [31:0] y;
    x = flush_subnormal(a);
    y = flush_subnormal(b);
    // ties go to b for min and to a for max.
    case (op)
        fpu_pkg::FPU_ADD: return truncated_sum(x, y);
        fpu_pkg::FPU_SUB: return truncated_sum(x, {~y[31], y[30:0]});
        fpu_pkg::FPU_MIN: return signed_less(x, y) ? x : y;
        default:          return signed_less(x, y) ? y : x;
    endcase
endfunction

`endif

// ==== verif/fpu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpu_tb;

    localparam int          CLK_PERIOD   = 40;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          RESET_CYCLES = 3;
    localparam int          ACK_LATENCY  = 5;
    localparam int          ACK_LIMIT    = 20;
    localparam int          N_DIRECTED   = 35;
    localparam int          N_RANDOM     = 48;
    localparam int          TRANS_CYCLES = 10;
    localparam int          MARGIN       = 100;
    localparam logic [31:0] SEED         = 32'd97528;

    logic              clk;
    logic              rst;
    logic              req;
    fpu_pkg::fpu_req_t request;
    logic              ack;
    fpu_pkg::fp_word_u result;

    logic [31:0] lfsr_state;
    string       cur_test;
    int          checks;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    `include "fpu_ref_model.svh"

    fpu_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .request (request),
        .ack     (ack),
        .result  (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // each transaction fits in TRANS_CYCLES.
    initial begin
        #((RESET_CYCLES + (N_DIRECTED + N_RANDOM) * TRANS_CYCLES + MARGIN) * CLK_PERIOD);
        $display("watchdog: the run did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    // galois lfsr stepped once per bit.
    function automatic logic lfsr_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_bit()};
        end
        return value;
    endfunction

    // exponent stays between 100 and 131.
    function automatic logic [31:0] random_operand();
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
        sign = random_bits(1) != 0;
        exp  = 8'd100 + 8'(random_bits(5));
        frac = 23'(random_bits(23));
        return {sign, exp, frac};
    endfunction

    // inputs change just after the rising edge.
    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("error %s %s: expected %08h, actual %08h", cur_test, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string message);
        errors++;
        $display("%s: %s", cur_test, message);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("%s: failed with %0d errors", cur_test, errors - test_errors);
        end else begin
            $display("%s: passed", cur_test);
        end
    endtask

    // one full four-phase exchange.
    // handshake timing is checked on every call.
    task automatic run_transaction(input fpu_pkg::fpu_op_e op, input logic [31:0] a,
                                   input logic [31:0] b, input int hold);
        logic [31:0] expected;
        string       what;
        int          waited;
        expected      = expected_result(op, a, b);
        what          = $sformatf("%s %08h %08h", op.name(), a, b);
        request.op    = op;
        request.a.raw = a;
        request.b.raw = b;
        req           = 1'b1;
        // this edge samples req in idle.
        step();
        waited = 0;
        while (!ack && waited < ACK_LIMIT) begin
            step();
            waited++;
        end
        checks++;
        assert (ack) else begin
            report_failure($sformatf("no ack within %0d cycles for %s", ACK_LIMIT, what));
        end
        if (ack) begin
            check_value({what, " ack latency"}, ACK_LATENCY, waited);
            check_value(what, expected, result.raw);
            for (int i = 0; i < hold; i++) begin
                step();
                checks++;
                assert (ack) else report_failure("ack fell while req was still high");
            end
        end
        req = 1'b0;
        step();
        checks++;
        assert (!ack) else report_failure("ack stayed high after req fell");
    endtask

    task automatic check_handshake();
        start_test("handshake");
        checks++;
        assert (!ack) else report_failure("ack is high after reset");
        check_value("result after reset", 32'h0, result.raw);
        // a long hold and then a request right after ack falls.
        run_transaction(fpu_pkg::FPU_ADD, 32'h3f800000, 32'h40000000, 3);
        run_transaction(fpu_pkg::FPU_SUB, 32'h40400000, 32'h3f800000, 0);
        finish_test();
    endtask

    task automatic add_and_subtract();
        start_test("add_sub");
        run_transaction(fpu_pkg::FPU_ADD, 32'h3f800000, 32'h3f800000, 0);
        run_transaction(fpu_pkg::FPU_ADD, 32'h3fc00000, 32'h3fa00000, 0);
        // exponent gap of one drops a set bit.
        run_transaction(fpu_pkg::FPU_ADD, 32'h3f800001, 32'h3f000001, 0);
        run_transaction(fpu_pkg::FPU_SUB, 32'h40000000, 32'h3f800000, 0);
        run_transaction(fpu_pkg::FPU_ADD, 32'hc0b00000, 32'h40100000, 0);
        // gaps of 23 and 24.
        run_transaction(fpu_pkg::FPU_ADD, 32'h3f800000, 32'h34000000, 0);
        run_transaction(fpu_pkg::FPU_SUB, 32'h3f800000, 32'h34000000, 0);
        run_transaction(fpu_pkg::FPU_ADD, 32'h4b000001, 32'h3f400000, 0);
        // gap of 67 where the small operand vanishes.
        run_transaction(fpu_pkg::FPU_ADD, 32'h3f800000, 32'h1e3ce508, 0);
        run_transaction(fpu_pkg::FPU_SUB, 32'h3f800000, 32'h1e3ce508, 0);
        finish_test();
    endtask

    task automatic cancel_and_normalize();
        start_test("cancel");
        run_transaction(fpu_pkg::FPU_SUB, 32'h3f800001, 32'h3f800000, 0);
        run_transaction(fpu_pkg::FPU_SUB, 32'h3fffffff, 32'h3ffffffe, 0);
        run_transaction(fpu_pkg::FPU_SUB, 32'h40000000, 32'h3fffffff, 0);
        // equal values give plus zero.
        run_transaction(fpu_pkg::FPU_SUB, 32'h42f6e979, 32'h42f6e979, 0);
        run_transaction(fpu_pkg::FPU_ADD, 32'hc1200000, 32'h41200000, 0);
        finish_test();
    endtask

    task automatic pick_min_max();
        start_test("min_max");
        run_transaction(fpu_pkg::FPU_MIN, 32'h3f800000, 32'h40000000, 0);
        run_transaction(fpu_pkg::FPU_MAX, 32'h3f800000, 32'h40000000, 0);
        run_transaction(fpu_pkg::FPU_MIN, 32'hbf800000, 32'h40000000, 0);
        run_transaction(fpu_pkg::FPU_MAX, 32'hbf800000, 32'h40000000, 0);
        // positive a against negative b.
        run_transaction(fpu_pkg::FPU_MIN, 32'h40000000, 32'hbf800000, 0);
        run_transaction(fpu_pkg::FPU_MAX, 32'h40000000, 32'hbf800000, 0);
        run_transaction(fpu_pkg::FPU_MIN, 32'hc0400000, 32'hc0000000, 0);
        run_transaction(fpu_pkg::FPU_MAX, 32'hc0400000, 32'hc0000000, 0);
        // same exponent with the order set by the fraction.
        run_transaction(fpu_pkg::FPU_MIN, 32'h3fc00000, 32'h3fa00000, 0);
        run_transaction(fpu_pkg::FPU_MAX, 32'h3fc00000, 32'h3fa00000, 0);
        run_transaction(fpu_pkg::FPU_MIN, 32'h80000000, 32'h00000000, 0);
        run_transaction(fpu_pkg::FPU_MAX, 32'h80000000, 32'h00000000, 0);
        finish_test();
    endtask

    task automatic edge_rules();
        start_test("edges");
        // subnormals act as signed zero.
        run_transaction(fpu_pkg::FPU_ADD, 32'h00400000, 32'h3f800000, 0);
        run_transaction(fpu_pkg::FPU_ADD, 32'h00000001, 32'h807fffff, 0);
        run_transaction(fpu_pkg::FPU_MIN, 32'h80000001, 32'h3f800000, 0);
        // overflow saturates with the sign.
        run_transaction(fpu_pkg::FPU_ADD, 32'h7f7fffff, 32'h7f7fffff, 0);
        run_transaction(fpu_pkg::FPU_SUB, 32'hff7fffff, 32'h7f7fffff, 0);
        // result below the normal range.
        run_transaction(fpu_pkg::FPU_SUB, 32'h80800001, 32'h80800000, 0);
        finish_test();
    endtask

    task automatic random_add_sub();
        logic [31:0]      a;
        logic [31:0]      b;
        fpu_pkg::fpu_op_e op;
        start_test("random");
        for (int i = 0; i < N_RANDOM; i++) begin
            a  = random_operand();
            b  = random_operand();
            op = (random_bits(1) != 0) ? fpu_pkg::FPU_SUB : fpu_pkg::FPU_ADD;
            run_transaction(op, a, b, 0);
        end
        finish_test();
    endtask

    initial begin
        rst          = 1'b1;
        req          = 1'b0;
        request      = '0;
        lfsr_state   = SEED;
        cur_test     = "";
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        check_handshake();
        add_and_subtract();
        cancel_and_normalize();
        pick_min_max();
        edge_rules();
        random_add_sub();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/fpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// four-phase req/ack front end.
// one request at a time goes into the pipeline.
module fpu_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  fpu_pkg::fpu_req_t request,
    output logic              ack,
    output fpu_pkg::fp_word_u result
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_DONE
    } state_e;

    state_e            state;
    logic              in_valid;
    logic              out_valid;
    fpu_pkg::fp_word_u fpu_result;

    // request stays stable while req is high.
    // it feeds the pipeline directly.
    fpu i_fpu (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .request   (request),
        .out_valid (out_valid),
        .result    (fpu_result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            in_valid <= 1'b0;
            ack      <= 1'b0;
            result   <= '0;
        end else begin
            // in_valid is a single-cycle pulse.
            in_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        in_valid <= 1'b1;
                        state    <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    // hold the result for the requester.
                    if (out_valid) begin
                        result <= fpu_result;
                        state  <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // ack follows req until the requester lets go.
                    if (req) begin
                        ack <= 1'b1;
                    end else begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/fpu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpu_macros.svh"

// three-stage add pipeline.
// align, add, then normalize and pack.
module fpu (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  fpu_pkg::fpu_req_t request,
    output logic              out_valid,
    output fpu_pkg::fp_word_u result
);

    localparam int LZ_W = $clog2(`FPU_SUM_W);

    fpu_pkg::fpu_aligned_t aligned_d;
    fpu_pkg::fpu_aligned_t aligned_q;
    logic                  valid1_q;
    logic                  minmax;
    logic [`FPU_SUM_W-1:0] add_a;
    logic [`FPU_SUM_W-1:0] add_b;
    logic [`FPU_SUM_W-1:0] add_s;
    fpu_pkg::fpu_sum_t     sum_d;
    fpu_pkg::fpu_sum_t     sum_q;
    logic                  valid2_q;
    logic                  sum_sign;
    logic [`FPU_SUM_W-1:0] sum_abs;
    logic [`FPU_SUM_W-1:0] enc_in;
    fpu_pkg::fpu_sum_t     sum_sm;
    logic [LZ_W-1:0]       lead_zeros;
    logic                  enc_none;
    fpu_pkg::fp_word_u     result_d;

    // stage one.
    fpu_align i_align (
        .request (request),
        .aligned (aligned_d)
    );

    // stage two.
    // min and max ignore the sum, so the adder inputs sit at zero for them.
    assign minmax = (aligned_q.op == fpu_pkg::FPU_MIN) || (aligned_q.op == fpu_pkg::FPU_MAX);
    assign add_a  = minmax ? '0 : aligned_q.sig_big;
    assign add_b  = minmax ? '0 : aligned_q.sig_small;

    adder #(.WIDTH(`FPU_SUM_W)) i_adder (
        .cin  (1'b0),
        .a    (add_a),
        .b    (add_b),
        .s    (add_s),
        .cout ()
    );

    always_comb begin
        sum_d.sum        = add_s;
        sum_d.exp        = aligned_q.exp;
        sum_d.pick       = aligned_q.pick;
        sum_d.pick_final = aligned_q.pick_final;
    end

    // stage three.
    assign sum_sign = sum_q.sum[`FPU_SUM_W-1];
    assign sum_abs  = sum_sign ? (~sum_q.sum + 1'b1) : sum_q.sum;

    // bit-reversed magnitude.
    // the lowest set bit is then the leading-zero count.
    always_comb begin
        for (int i = 0; i < `FPU_SUM_W; i++) begin
            enc_in[i] = sum_abs[`FPU_SUM_W-1-i];
        end
    end

    priority_encoder #(.WIDTH(`FPU_SUM_W)) i_encoder (
        .in   (enc_in),
        .out  (lead_zeros),
        .none (enc_none)
    );

    // the magnitude never reaches the top bit, which carries the sign onward.
    always_comb begin
        sum_sm     = sum_q;
        sum_sm.sum = {sum_sign, sum_abs[`FPU_SUM_W-2:0]};
    end

    fpu_normalize i_normalize (
        .sum        (sum_sm),
        .lead_zeros (lead_zeros),
        .none       (enc_none),
        .result     (result_d)
    );

    // valid chain and final result.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid1_q  <= 1'b0;
            valid2_q  <= 1'b0;
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            valid1_q  <= in_valid;
            valid2_q  <= valid1_q;
            out_valid <= valid2_q;
            if (valid2_q) begin
                result <= result_d;
            end
        end
    end

    // stage payloads.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            aligned_q <= aligned_d;
        end
        if (valid1_q) begin
            sum_q <= sum_d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/fpu_normalize.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpu_macros.svh"

// normalize the sum and pack the result word.
// sum arrives in sign-magnitude form, sign in the top bit.
module fpu_normalize (
    input  fpu_pkg::fpu_sum_t               sum,
    input  logic [$clog2(`FPU_SUM_W)-1:0]   lead_zeros,
    input  logic                            none,
    output fpu_pkg::fp_word_u               result
);

    localparam int EXP_CW     = `FPU_EXP_W + 2;
    localparam int EXP_MAX    = (1 << `FPU_EXP_W) - 1;
    localparam int TOP_OFFSET = `FPU_SUM_W - 1 - `FPU_HIDDEN_POS;

    logic                  sign;
    logic [`FPU_SUM_W-1:0] mag;
    logic [`FPU_SUM_W-1:0] norm;
    logic [EXP_CW-1:0]     exp_calc;
    logic                  underflow;
    logic                  overflow;

    assign sign = sum.sum[`FPU_SUM_W-1];
    assign mag  = {1'b0, sum.sum[`FPU_SUM_W-2:0]};

    // leading one moves to the msb.
    assign norm = mag << lead_zeros;

    // exponent tracks where the leading one was.
    // one leading zero is a carry and moves the exponent up one.
    // the wide form goes negative on deep cancellation.
    assign exp_calc = EXP_CW'(sum.exp) + EXP_CW'(TOP_OFFSET) - EXP_CW'(lead_zeros);

    assign underflow = exp_calc[EXP_CW-1] || (exp_calc == '0);
    assign overflow  = !exp_calc[EXP_CW-1] && (exp_calc >= EXP_CW'(EXP_MAX));

    always_comb begin
        result = '0;
        if (sum.pick_final) begin
            // min and max return the chosen input word.
            result = sum.pick;
        end else if (none) begin
            // exact cancellation gives positive zero.
            result = '0;
        end else if (underflow) begin
            // too small for a normal number, flush to signed zero.
            result.f.sign = sign;
        end else if (overflow) begin
            // saturate to infinity.
            result.f.sign = sign;
            result.f.exp  = '1;
        end else begin
            // hidden bit drops off, low bits are truncated.
            result.f.sign = sign;
            result.f.exp  = exp_calc[`FPU_EXP_W-1:0];
            result.f.frac = norm[`FPU_SUM_W-2 -: `FPU_FRAC_W];
        end
    end

endmodule

`default_nettype wire

// ==== hw/fpu_align.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpu_macros.svh"

// unpack, flush, order and align both operands.
module fpu_align (
    input  fpu_pkg::fpu_req_t     request,
    output fpu_pkg::fpu_aligned_t aligned
);

    localparam int GUARD_W = `FPU_HIDDEN_POS - `FPU_FRAC_W;
    localparam int MAG_MSB = `FPU_EXP_W + `FPU_FRAC_W - 1;

    fpu_pkg::fp_word_u     op_a;
    fpu_pkg::fp_word_u     op_b;
    fpu_pkg::fp_word_u     op_big;
    fpu_pkg::fp_word_u     op_small;
    logic                  swap;
    logic                  mag_eq;
    logic                  a_lt_b;
    logic [`FPU_EXP_W-1:0] exp_diff;
    logic [`FPU_SUM_W-1:0] mag_big;
    logic [`FPU_SUM_W-1:0] mag_small;
    logic [`FPU_SUM_W-1:0] mag_shift;
    logic [`FPU_SUM_W-1:0] mag_back;
    logic                  sticky;
    logic                  borrow;

    // hidden bit in front of the fraction and guard bits below it.
    function automatic logic [`FPU_SUM_W-1:0] unpack_mag(input fpu_pkg::fp_word_u w);
        if (w.f.exp == '0) begin
            return '0;
        end
        return {2'b00, 1'b1, w.f.frac, {GUARD_W{1'b0}}};
    endfunction

    function automatic logic [`FPU_SUM_W-1:0] apply_sign(
        input logic                  sign,
        input logic [`FPU_SUM_W-1:0] mag
    );
        return sign ? (~mag + 1'b1) : mag;
    endfunction

    always_comb begin
        op_a = request.a;
        op_b = request.b;
        // subtract is an add of the negated b.
        if (request.op == fpu_pkg::FPU_SUB) begin
            op_b.f.sign = ~op_b.f.sign;
        end
        // zero exponent means zero or subnormal.
        // both become signed zero.
        if (op_a.f.exp == '0) begin
            op_a.f.frac = '0;
        end
        if (op_b.f.exp == '0) begin
            op_b.f.frac = '0;
        end
    end

    // exponent sits above fraction so the raw bits order by magnitude.
    assign swap     = op_b.raw[MAG_MSB:0] > op_a.raw[MAG_MSB:0];
    assign mag_eq   = op_b.raw[MAG_MSB:0] == op_a.raw[MAG_MSB:0];
    assign op_big   = swap ? op_b : op_a;
    assign op_small = swap ? op_a : op_b;

    assign exp_diff  = op_big.f.exp - op_small.f.exp;
    assign mag_big   = unpack_mag(op_big);
    assign mag_small = unpack_mag(op_small);

    // shifts past the whole word leave nothing.
    assign mag_shift = (exp_diff >= `FPU_SUM_W) ? '0 : mag_small >> exp_diff;
    // bits that fell off show up as a mismatch after shifting back.
    assign mag_back  = mag_shift << exp_diff;
    assign sticky    = mag_back != mag_small;

    // lost bits on an effective subtract take one more lsb off the result.
    // the truncated sum then stays toward zero.
    assign borrow = sticky & (op_big.f.sign ^ op_small.f.sign);

    // signed order for min and max.
    always_comb begin
        case ({op_a.f.sign, op_b.f.sign})
            2'b00:   a_lt_b = swap;
            2'b11:   a_lt_b = ~swap & ~mag_eq;
            2'b10:   a_lt_b = 1'b1;
            default: a_lt_b = 1'b0;
        endcase
    end

    always_comb begin
        aligned.op        = request.op;
        aligned.sig_big   = apply_sign(op_big.f.sign, mag_big);
        aligned.sig_small = apply_sign(op_small.f.sign, mag_shift + `FPU_SUM_W'(borrow));
        aligned.exp       = op_big.f.exp;
        if (request.op == fpu_pkg::FPU_MIN) begin
            aligned.pick = a_lt_b ? op_a : op_b;
        end else begin
            aligned.pick = a_lt_b ? op_b : op_a;
        end
        aligned.pick_final = (request.op == fpu_pkg::FPU_MIN) ||
                             (request.op == fpu_pkg::FPU_MAX);
    end

endmodule

`default_nettype wire

// ==== hw/priority_encoder.sv ====
`timescale 1ns/1ns
`default_nettype none

// finds the lowest set bit.
// none flags an all-zero input.
module priority_encoder #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]         in,
    output logic [$clog2(WIDTH)-1:0] out,
    output logic                     none
);

    localparam int OUT_W = $clog2(WIDTH);

    // scan from the top down.
    // the last hit is the lowest set bit.
    always_comb begin
        out = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (in[i]) begin
                out = OUT_W'(i);
            end
        end
    end

    // index reads as zero when nothing is set.
    assign none = ~|in;

endmodule

`default_nettype wire

// ==== hw/adder.sv ====
`timescale 1ns/1ns
`default_nettype none

// two's-complement adder.
// kept on its own so a faster structure can drop in later.
module adder #(
    parameter int WIDTH = 32
) (
    input  logic             cin,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] s,
    output logic             cout
);

    // one extra bit catches the carry out of the top.
    logic [WIDTH:0] full;

    // zero-extend both operands.
    // carry-in enters at the bottom.
    assign full = {1'b0, a} + {1'b0, b} + {{WIDTH{1'b0}}, cin};

    // low bits are the sum.
    assign s = full[WIDTH-1:0];

    // unsigned carry out of the msb.
    assign cout = full[WIDTH];

endmodule

`default_nettype wire

// ==== hw/fpu_pkg.sv ====
`default_nettype none

`include "fpu_macros.svh"

package fpu_pkg;

    // operation code from the requester.
    typedef enum logic [1:0] {
        FPU_ADD = 2'd0,
        FPU_SUB = 2'd1,
        FPU_MIN = 2'd2,
        FPU_MAX = 2'd3
    } fpu_op_e;

    // sign, biased exponent and stored fraction.
    typedef struct packed {
        logic                   sign;
        logic [`FPU_EXP_W-1:0]  exp;
        logic [`FPU_FRAC_W-1:0] frac;
    } fp_fields_t;

    // one float word, seen as raw bits or as its fields.
    typedef union packed {
        logic [`FPU_EXP_W+`FPU_FRAC_W:0] raw;
        fp_fields_t                      f;
    } fp_word_u;

    // one request into the unit.
    typedef struct packed {
        fpu_op_e  op;
        fp_word_u a;
        fp_word_u b;
    } fpu_req_t;

    // stage one to stage two.
    // sig_big belongs to the operand with the larger magnitude.
    typedef struct packed {
        fpu_op_e               op;
        logic [`FPU_SUM_W-1:0] sig_big;
        logic [`FPU_SUM_W-1:0] sig_small;
        logic [`FPU_EXP_W-1:0] exp;
        fp_word_u              pick;
        logic                  pick_final;
    } fpu_aligned_t;

    // stage two to stage three.
    typedef struct packed {
        logic [`FPU_SUM_W-1:0] sum;
        logic [`FPU_EXP_W-1:0] exp;
        fp_word_u              pick;
        logic                  pick_final;
    } fpu_sum_t;

endpackage

`default_nettype wire

// ==== hw/fpu_macros.svh ====
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// binary32 field widths.
`define FPU_EXP_W 8
`define FPU_FRAC_W 23

// exponent bias of the stored format.
`define FPU_EXP_BIAS 127

// signed significand sum.
// sign, carry headroom, hidden bit, fraction and six guard bits.
`define FPU_SUM_W 32

// bit where the hidden one sits in an aligned significand.
`define FPU_HIDDEN_POS (`FPU_SUM_W - 3)

`endif
